// File: logic/snakePkg.sv
`default_nettype none

package snakePkg;

	localparam int GRID_W = 16;
	localparam int GRID_H = 16;

	typedef enum logic [2:0] {
		cellEmpty,
		cellBorder,
		cellBody,
		cellHead,
		cellApple
	} cellKind;

	// Values line up with the dirButtons bit order
	typedef enum logic [1:0] {dirUp, dirDown, dirLeft, dirRight} dirKind;

	localparam logic [7:0] COLOUR_EMPTY = 8'h00;
	localparam logic [7:0] COLOUR_BORDER = 8'h92;
	localparam logic [7:0] COLOUR_BODY = 8'h1c;
	localparam logic [7:0] COLOUR_HEAD = 8'h1f;
	localparam logic [7:0] COLOUR_APPLE = 8'he0;
	localparam logic [7:0] FRAME_CMD = 8'h2c; // Memory write command

	localparam logic [7:0] LFSR_SEED = 8'h5a;
	localparam logic [7:0] LFSR_TAPS = 8'hb8;

	localparam logic [3:0] START_X = 4'd8;
	localparam logic [3:0] START_Y = 4'd8;

	function automatic logic isBorder(input logic [3:0] x, input logic [3:0] y);
		return x == 4'd0 || y == 4'd0 || x == 4'(GRID_W - 1) || y == 4'(GRID_H - 1);
	endfunction

endpackage

`default_nettype wire

// File: logic/cellLink.sv
`timescale 1ns/1ps
`default_nettype none

interface cellLink;
	logic push;
	snakePkg::cellKind pushCell;
	logic pushFirst; // First cell of a frame
	logic full;
	logic pop;
	snakePkg::cellKind popCell;
	logic popFirst;
	logic empty;

	modport producer(output push, pushCell, pushFirst, input full);

	modport store(
		input push, pushCell, pushFirst, pop,
		output full, popCell, popFirst, empty
	);

	modport consumer(output pop, input popCell, popFirst, empty);
endinterface

`default_nettype wire

// File: logic/pixelScan.sv
`timescale 1ns/1ps
`default_nettype none

module pixelScan (
	input logic clk,
	input logic rstN,
	cellLink.producer link,
	output logic [3:0] qx,
	output logic [3:0] qy,
	input logic headHit,
	input logic bodyHit,
	input logic [3:0] appleX,
	input logic [3:0] appleY,
	output logic frameTick
);
	logic [3:0] x;
	logic [3:0] y;
	logic tick;
	logic lastCell;
	snakePkg::cellKind kind;

	assign lastCell = x == 4'(snakePkg::GRID_W - 1) && y == 4'(snakePkg::GRID_H - 1);

	always_comb begin
		if (headHit)
			kind = snakePkg::cellHead;
		else if (bodyHit)
			kind = snakePkg::cellBody;
		else if (x == appleX && y == appleY)
			kind = snakePkg::cellApple;
		else if (snakePkg::isBorder(x, y))
			kind = snakePkg::cellBorder;
		else
			kind = snakePkg::cellEmpty;
	end

	// Hold off for the tick cycle so the game state settles first
	assign link.push = !link.full && !tick;
	assign link.pushCell = kind;
	assign link.pushFirst = x == 4'd0 && y == 4'd0;
	assign qx = x;
	assign qy = y;
	assign frameTick = tick;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			x <= 4'd0;
			y <= 4'd0;
			tick <= 1'b0;
		end else begin
			tick <= link.push && lastCell;
			if (link.push) begin
				x <= x + 4'd1; // wraps at the row end
				if (x == 4'(snakePkg::GRID_W - 1))
					y <= y + 4'd1;
			end
		end
	end
endmodule

`default_nettype wire

// File: logic/cellFifo.sv
`timescale 1ns/1ps
`default_nettype none

module cellFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input logic clk,
	input logic rstN,
	cellLink.store inLink,
	cellLink.store outLink
);
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	snakePkg::cellKind cellMem [FIFO_DEPTH];
	logic firstMem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;
	logic full;
	logic empty;

	assign full = count == (PTR_W + 1)'(FIFO_DEPTH);
	assign empty = count == '0;

	// Both links see the same levels and head entry
	assign inLink.full = full;
	assign outLink.full = full;
	assign inLink.empty = empty;
	assign outLink.empty = empty;
	assign inLink.popCell = cellMem[rdPtr];
	assign outLink.popCell = cellMem[rdPtr];
	assign inLink.popFirst = firstMem[rdPtr];
	assign outLink.popFirst = firstMem[rdPtr];

	always_ff @(posedge clk) begin
		if (inLink.push) begin
			cellMem[wrPtr] <= inLink.pushCell;
			firstMem[wrPtr] <= inLink.pushFirst;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (inLink.push)
				wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (outLink.pop)
				rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (inLink.push && !outLink.pop)
				count <= count + 1'b1;
			else if (outLink.pop && !inLink.push)
				count <= count - 1'b1;
		end
	end
endmodule

`default_nettype wire

// File: logic/lcdWriter.sv
`timescale 1ns/1ps
`default_nettype none

module lcdWriter (
	input logic clk,
	input logic rstN,
	cellLink.consumer link,
	output logic wr,
	output logic dcx,
	output logic [7:0] data
);
	typedef enum logic [2:0] {idle, cmdLow, cmdHigh, dataLow, dataHigh} writerState;

	writerState state;
	logic canStart;
	logic startCmd;

	function automatic logic [7:0] colourOf(input snakePkg::cellKind kind);
		case (kind)
			snakePkg::cellBorder: return snakePkg::COLOUR_BORDER;
			snakePkg::cellBody: return snakePkg::COLOUR_BODY;
			snakePkg::cellHead: return snakePkg::COLOUR_HEAD;
			snakePkg::cellApple: return snakePkg::COLOUR_APPLE;
			default: return snakePkg::COLOUR_EMPTY;
		endcase
	endfunction

	assign canStart = (state == idle || state == dataHigh) && !link.empty;
	assign startCmd = canStart && link.popFirst;
	// The first cell stays queued until its command byte is out
	assign link.pop = (canStart && !link.popFirst) || state == cmdHigh;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			wr <= 1'b1;
			dcx <= 1'b1;
			data <= 8'h00;
		end else begin
			case (state)
				cmdLow: begin
					wr <= 1'b1;
					state <= cmdHigh;
				end
				dataLow: begin
					wr <= 1'b1;
					state <= dataHigh;
				end
				default: begin
					if (startCmd) begin
						data <= snakePkg::FRAME_CMD;
						dcx <= 1'b0;
						wr <= 1'b0;
						state <= cmdLow;
					end else if (link.pop) begin
						data <= colourOf(link.popCell);
						dcx <= 1'b1;
						wr <= 1'b0;
						state <= dataLow;
					end else
						state <= idle;
				end
			endcase
		end
	end
endmodule

`default_nettype wire

// File: logic/snakeBody.sv
`timescale 1ns/1ps
`default_nettype none

module snakeBody #(
	parameter int MAX_LENGTH = 16
) (
	input logic clk,
	input logic rstN,
	input logic [3:0] dirButtons,
	input logic grow,
	input logic step,
	input logic [3:0] qx,
	input logic [3:0] qy,
	output logic headHit,
	output logic bodyHit,
	output logic [3:0] nextX,
	output logic [3:0] nextY,
	output logic selfHit
);
	localparam int LEN_W = $clog2(MAX_LENGTH + 1);

	logic [3:0] headX;
	logic [3:0] headY;
	logic [3:0] bodyX [1:MAX_LENGTH-1]; // Segment 1 follows the head
	logic [3:0] bodyY [1:MAX_LENGTH-1];
	logic [LEN_W-1:0] length;
	snakePkg::dirKind moveDir;
	snakePkg::dirKind nextDir;
	snakePkg::dirKind baseDir;
	snakePkg::dirKind candidate;
	logic pressed;
	logic move;

	assign move = grow || step;
	assign baseDir = move ? nextDir : moveDir;

	always_comb begin
		pressed = 1'b0;
		candidate = nextDir;
		for (int i = 3; i >= 0; i--) begin // lowest button wins
			if (dirButtons[i]) begin
				pressed = 1'b1;
				candidate = snakePkg::dirKind'(i);
			end
		end
	end

	always_comb begin
		nextX = headX;
		nextY = headY;
		case (nextDir)
			snakePkg::dirUp: nextY = headY - 4'd1;
			snakePkg::dirDown: nextY = headY + 4'd1;
			snakePkg::dirLeft: nextX = headX - 4'd1;
			default: nextX = headX + 4'd1;
		endcase
	end

	always_comb begin
		headHit = qx == headX && qy == headY;
		bodyHit = 1'b0;
		selfHit = 1'b0;
		for (int i = 1; i < MAX_LENGTH; i++) begin
			if (LEN_W'(i) < length && qx == bodyX[i] && qy == bodyY[i])
				bodyHit = 1'b1;
			// Tail leaves on a plain move
			if (LEN_W'(i + 1) < length && nextX == bodyX[i] && nextY == bodyY[i])
				selfHit = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			headX <= snakePkg::START_X;
			headY <= snakePkg::START_Y;
			length <= LEN_W'(1);
			moveDir <= snakePkg::dirRight;
			nextDir <= snakePkg::dirRight;
		end else begin
			if (pressed && candidate != snakePkg::dirKind'(baseDir ^ 2'b01))
				nextDir <= candidate;
			if (move) begin
				moveDir <= nextDir;
				headX <= nextX;
				headY <= nextY;
			end
			if (grow && length < LEN_W'(MAX_LENGTH))
				length <= length + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (move) begin
			bodyX[1] <= headX;
			bodyY[1] <= headY;
			for (int i = 2; i < MAX_LENGTH; i++) begin
				bodyX[i] <= bodyX[i-1];
				bodyY[i] <= bodyY[i-1];
			end
		end
	end
endmodule

`default_nettype wire

// File: logic/appleGen.sv
`timescale 1ns/1ps
`default_nettype none

module appleGen (
	input logic clk,
	input logic rstN,
	input logic grow,
	output logic [3:0] appleX,
	output logic [3:0] appleY
);
	logic [7:0] lfsr;

	function automatic logic [7:0] stepLfsr(input logic [7:0] s);
		return s[0] ? (s >> 1) ^ snakePkg::LFSR_TAPS : s >> 1;
	endfunction

	// Pull edge values one cell inward
	function automatic logic [3:0] clampIn(input logic [3:0] v);
		if (v == 4'd0)
			return 4'd1;
		if (v == 4'd15)
			return 4'd14;
		return v;
	endfunction

	assign appleX = clampIn(lfsr[3:0]);
	assign appleY = clampIn(lfsr[7:4]);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			lfsr <= stepLfsr(snakePkg::LFSR_SEED);
		else if (grow)
			lfsr <= stepLfsr(lfsr);
	end
endmodule

`default_nettype wire

// File: logic/collisionScore.sv
`timescale 1ns/1ps
`default_nettype none

module collisionScore (
	input logic clk,
	input logic rstN,
	input logic en,
	input logic frameTick,
	input logic [3:0] nextX,
	input logic [3:0] nextY,
	input logic selfHit,
	input logic [3:0] appleX,
	input logic [3:0] appleY,
	output logic grow,
	output logic step,
	output logic die,
	output logic [3:0] scoreTens,
	output logic [3:0] scoreOnes,
	output logic gameOver
);
	logic decide;
	logic onApple;

	assign decide = frameTick && en && !gameOver;
	assign onApple = nextX == appleX && nextY == appleY;

	assign die = decide && (snakePkg::isBorder(nextX, nextY) || selfHit);
	assign grow = decide && !die && onApple;
	assign step = decide && !die && !onApple;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			scoreTens <= 4'd0;
			scoreOnes <= 4'd0;
			gameOver <= 1'b0;
		end else begin
			if (die)
				gameOver <= 1'b1;
			if (grow && !(scoreTens == 4'd9 && scoreOnes == 4'd9)) begin // holds at 99
				if (scoreOnes == 4'd9) begin
					scoreOnes <= 4'd0;
					scoreTens <= scoreTens + 4'd1;
				end else
					scoreOnes <= scoreOnes + 4'd1;
			end
		end
	end
endmodule

`default_nettype wire

// File: logic/scoreDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module scoreDisplay #(
	parameter int DIGIT_PERIOD_LOG = 6
) (
	input logic clk,
	input logic rstN,
	input logic [3:0] tens,
	input logic [3:0] ones,
	output logic [6:0] segOut,
	output logic digitSel
);
	logic [DIGIT_PERIOD_LOG-1:0] divCount;
	logic [3:0] digit;

	assign digit = digitSel ? tens : ones;

	always_comb begin
		case (digit) // Segments gfedcba
			4'd0: segOut = 7'h3f;
			4'd1: segOut = 7'h06;
			4'd2: segOut = 7'h5b;
			4'd3: segOut = 7'h4f;
			4'd4: segOut = 7'h66;
			4'd5: segOut = 7'h6d;
			4'd6: segOut = 7'h7d;
			4'd7: segOut = 7'h07;
			4'd8: segOut = 7'h7f;
			4'd9: segOut = 7'h6f;
			default: segOut = 7'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			divCount <= '0;
			digitSel <= 1'b0;
		end else begin
			divCount <= divCount + 1'b1;
			if (&divCount)
				digitSel <= ~digitSel;
		end
	end
endmodule

`default_nettype wire

// File: logic/gameTop.sv
`timescale 1ns/1ps
`default_nettype none

module gameTop #(
	parameter int MAX_LENGTH = 16,
	parameter int FIFO_DEPTH = 8,
	parameter int DIGIT_PERIOD_LOG = 6
) (
	input logic clk,
	input logic rstN,
	input logic en,
	input logic [3:0] dirButtons,
	output logic lcdWr,
	output logic lcdDcx,
	output logic [7:0] lcdData,
	output logic [6:0] segOut,
	output logic digitSel,
	output logic gameOver
);
	logic [3:0] qx;
	logic [3:0] qy;
	logic headHit;
	logic bodyHit;
	logic [3:0] appleX;
	logic [3:0] appleY;
	logic frameTick;
	logic [3:0] nextX;
	logic [3:0] nextY;
	logic selfHit;
	logic grow;
	logic step;
	logic [3:0] scoreTens;
	logic [3:0] scoreOnes;

	cellLink scanLink();
	cellLink drainLink();

	pixelScan scan (
		.clk(clk), .rstN(rstN), .link(scanLink),
		.qx(qx), .qy(qy), .headHit(headHit), .bodyHit(bodyHit),
		.appleX(appleX), .appleY(appleY), .frameTick(frameTick)
	);

	cellFifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo (
		.clk(clk), .rstN(rstN), .inLink(scanLink), .outLink(drainLink)
	);

	lcdWriter writer (
		.clk(clk), .rstN(rstN), .link(drainLink),
		.wr(lcdWr), .dcx(lcdDcx), .data(lcdData)
	);

	snakeBody #(.MAX_LENGTH(MAX_LENGTH)) body (
		.clk(clk), .rstN(rstN), .dirButtons(dirButtons), .grow(grow), .step(step),
		.qx(qx), .qy(qy), .headHit(headHit), .bodyHit(bodyHit),
		.nextX(nextX), .nextY(nextY), .selfHit(selfHit)
	);

	appleGen apple (
		.clk(clk), .rstN(rstN), .grow(grow), .appleX(appleX), .appleY(appleY)
	);

	collisionScore judge (
		.clk(clk), .rstN(rstN), .en(en), .frameTick(frameTick),
		.nextX(nextX), .nextY(nextY), .selfHit(selfHit),
		.appleX(appleX), .appleY(appleY),
		.grow(grow), .step(step), .die(),
		.scoreTens(scoreTens), .scoreOnes(scoreOnes), .gameOver(gameOver)
	);

	scoreDisplay #(.DIGIT_PERIOD_LOG(DIGIT_PERIOD_LOG)) score (
		.clk(clk), .rstN(rstN), .tens(scoreTens), .ones(scoreOnes),
		.segOut(segOut), .digitSel(digitSel)
	);
endmodule

`default_nettype wire

// File: tb/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Segment 0 is the head
logic [3:0] mSegX [MAX_LENGTH];
logic [3:0] mSegY [MAX_LENGTH];
int mLength;
logic [1:0] mMoveDir;
logic [1:0] mNextDir; // Turn waiting for the next move
logic [7:0] mLfsr;
logic [3:0] mTens;
logic [3:0] mOnes;
logic mOver;

function automatic logic [7:0] lfsrNext(input logic [7:0] s);
	logic [7:0] t;
	t = {1'b0, s[7:1]};
	if (s[0])
		t = t ^ snakePkg::LFSR_TAPS;
	return t;
endfunction

function automatic logic [3:0] insideCoord(input logic [3:0] v);
	return (v == 4'd0) ? 4'd1 : ((v == 4'd15) ? 4'd14 : v);
endfunction

function automatic logic [3:0] modelAppleX();
	return insideCoord(mLfsr[3:0]);
endfunction

function automatic logic [3:0] modelAppleY();
	return insideCoord(mLfsr[7:4]);
endfunction

function automatic logic onEdge(input logic [3:0] x, input logic [3:0] y);
	return x == 4'd0 || x == 4'd15 || y == 4'd0 || y == 4'd15;
endfunction

// Active-high gfedcba
function automatic logic [6:0] segmentsOf(input logic [3:0] digit);
	case (digit)
		4'd0: return 7'b0111111;
		4'd1: return 7'b0000110;
		4'd2: return 7'b1011011;
		4'd3: return 7'b1001111;
		4'd4: return 7'b1100110;
		4'd5: return 7'b1101101;
		4'd6: return 7'b1111101;
		4'd7: return 7'b0000111;
		4'd8: return 7'b1111111;
		4'd9: return 7'b1101111;
		default: return 7'b0000000;
	endcase
endfunction

function automatic logic [7:0] cellColour(input logic [3:0] x, input logic [3:0] y);
	if (x == mSegX[0] && y == mSegY[0])
		return snakePkg::COLOUR_HEAD;
	for (int i = 1; i < mLength; i++)
		if (x == mSegX[i] && y == mSegY[i])
			return snakePkg::COLOUR_BODY;
	if (x == modelAppleX() && y == modelAppleY())
		return snakePkg::COLOUR_APPLE;
	if (onEdge(x, y))
		return snakePkg::COLOUR_BORDER;
	return snakePkg::COLOUR_EMPTY;
endfunction

task automatic modelReset();
	for (int i = 0; i < MAX_LENGTH; i++) begin
		mSegX[i] = snakePkg::START_X;
		mSegY[i] = snakePkg::START_Y;
	end
	mLength = 1;
	mMoveDir = 2'd3; // right
	mNextDir = 2'd3;
	mLfsr = lfsrNext(snakePkg::LFSR_SEED);
	mTens = 4'd0;
	mOnes = 4'd0;
	mOver = 1'b0;
endtask

// Lowest pressed button, unless it reverses the last move
task automatic applyButtons(input logic [3:0] b);
	logic [1:0] pick;
	if (b[0])
		pick = 2'd0;
	else if (b[1])
		pick = 2'd1;
	else if (b[2])
		pick = 2'd2;
	else
		pick = 2'd3;
	if (b != 4'd0 && pick != (mMoveDir ^ 2'b01))
		mNextDir = pick;
endtask

task automatic modelAdvance(input logic [3:0] b, input logic enable);
	logic [3:0] nx;
	logic [3:0] ny;
	logic hitSelf;
	int score;
	applyButtons(b);
	nx = mSegX[0];
	ny = mSegY[0];
	case (mNextDir)
		2'd0: ny = ny - 4'd1;
		2'd1: ny = ny + 4'd1;
		2'd2: nx = nx - 4'd1;
		default: nx = nx + 4'd1;
	endcase
	hitSelf = 1'b0;
	for (int i = 1; i + 1 < mLength; i++) // tail moves away
		if (nx == mSegX[i] && ny == mSegY[i])
			hitSelf = 1'b1;
	if (enable && !mOver) begin
		if (onEdge(nx, ny) || hitSelf)
			mOver = 1'b1;
		else begin
			if (nx == modelAppleX() && ny == modelAppleY()) begin
				if (mLength < MAX_LENGTH)
					mLength++;
				mLfsr = lfsrNext(mLfsr);
				score = int'(mTens) * 10 + int'(mOnes);
				if (score < 99)
					score++;
				mTens = 4'(score / 10);
				mOnes = 4'(score % 10);
			end
			for (int i = MAX_LENGTH - 1; i > 0; i--) begin
				mSegX[i] = mSegX[i-1];
				mSegY[i] = mSegY[i-1];
			end
			mSegX[0] = nx;
			mSegY[0] = ny;
			mMoveDir = mNextDir;
			applyButtons(b); // Buttons still held after the move
		end
	end
endtask

`endif

// File: tb/tbGameTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbGameTop;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_FRAMES = 40;
	localparam int MAX_LENGTH = 16;
	localparam int FIFO_DEPTH = 8;
	localparam int DIGIT_PERIOD_LOG = 6;
	// 257 bytes of two cycles per frame, doubled
	localparam int WATCHDOG_NS = (NUM_FRAMES * 257 * 2 * 2 + RESET_CYCLES) * CLK_PERIOD;

	logic clk;
	logic rstN;
	logic en;
	logic [3:0] dirButtons;
	logic lcdWr;
	logic lcdDcx;
	logic [7:0] lcdData;
	logic [6:0] segOut;
	logic digitSel;
	logic gameOver;

	logic [31:0] rngState;
	logic [3:0] frameButtons; // Held for the whole frame
	logic frameEn;
	logic [7:0] frameBytes [256];
	int byteCount;
	int framesSeen;
	int cyclesRun; // Clock edges since reset release

	`include "tbModel.svh"

	gameTop #(
		.MAX_LENGTH(MAX_LENGTH),
		.FIFO_DEPTH(FIFO_DEPTH),
		.DIGIT_PERIOD_LOG(DIGIT_PERIOD_LOG)
	) UUT (
		.clk(clk), .rstN(rstN), .en(en), .dirButtons(dirButtons),
		.lcdWr(lcdWr), .lcdDcx(lcdDcx), .lcdData(lcdData),
		.segOut(segOut), .digitSel(digitSel), .gameOver(gameOver)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("mismatch at %0t ns: %s (got %0h, expected %0h)", $time, what, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "Stopped at the first error");
		end
	endtask

	// Steers around a reversal so the snake reaches the apple
	function automatic logic [3:0] towardApple();
		logic [1:0] want;
		if (modelAppleX() > mSegX[0])
			want = 2'd3;
		else if (modelAppleX() < mSegX[0])
			want = 2'd2;
		else if (modelAppleY() > mSegY[0])
			want = 2'd1;
		else
			want = 2'd0;
		if (want == (mMoveDir ^ 2'b01))
			want = want[1] ? ((modelAppleY() > mSegY[0]) ? 2'd1 : 2'd0) : 2'd3;
		return 4'b0001 << want;
	endfunction

	task drawStimulus();
		rngState = xorshift(rngState);
		if (mTens == 4'd0 && mOnes < 4'd2)
			frameButtons = (rngState[2:0] != 3'd0) ? towardApple() : rngState[7:4];
		else
			frameButtons = (rngState[3:0] == 4'd0) ? rngState[7:4] : 4'd0; // Mostly straight on
		frameEn = rngState[10:8] != 3'd0;
		dirButtons <= frameButtons;
		en <= frameEn;
	endtask

	task startFrame();
		logic [3:0] shownDigit;
		checkValue(32'(lcdData), 32'(snakePkg::FRAME_CMD), "command byte");
		if (framesSeen > 0) begin
			checkValue(32'(byteCount), 32'd256, "colour bytes in the previous frame");
			modelAdvance(frameButtons, frameEn);
		end
		checkValue(32'(gameOver), 32'(mOver), "gameOver level");
		checkValue(32'(digitSel), 32'((cyclesRun >> DIGIT_PERIOD_LOG) % 2), "digit select");
		shownDigit = digitSel ? mTens : mOnes;
		checkValue(32'(segOut), 32'(segmentsOf(shownDigit)), "seven-segment output");
		if (framesSeen == NUM_FRAMES) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			framesSeen++;
			byteCount = 0;
			drawStimulus();
		end
	endtask

	task takeByte();
		logic [3:0] cx;
		logic [3:0] cy;
		checkValue(32'(framesSeen > 0 && byteCount < 256), 32'd1, "colour byte outside a frame");
		cx = 4'(byteCount % 16);
		cy = 4'(byteCount / 16);
		if (mOver)
			checkValue(32'(lcdData), 32'(frameBytes[byteCount]), "frame changed after game over");
		checkValue(32'(lcdData), 32'(cellColour(cx, cy)),
			$sformatf("cell (%0d,%0d) of frame %0d", cx, cy, framesSeen));
		frameBytes[byteCount] = lcdData;
		byteCount++;
	endtask

	// The byte is taken at the edge that raises wr
	always @(posedge clk) begin
		if (rstN && !lcdWr) begin
			if (!lcdDcx)
				startFrame();
			else
				takeByte();
		end
		if (rstN)
			cyclesRun++;
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		en = 1'b0;
		dirButtons = 4'd0;
		frameButtons = 4'd0;
		frameEn = 1'b0;
		rngState = 32'h9d5df82e;
		byteCount = 0;
		framesSeen = 0;
		cyclesRun = 0;
		modelReset();
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: %0d frames were not drawn within %0d ns", NUM_FRAMES, WATCHDOG_NS);
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog expired");
	end
endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
logic/snakePkg.sv
logic/cellLink.sv
logic/pixelScan.sv
logic/cellFifo.sv
logic/lcdWriter.sv
logic/snakeBody.sv
logic/appleGen.sv
logic/collisionScore.sv
logic/scoreDisplay.sv
logic/gameTop.sv
tb/tbGameTop.sv

// File: run.sh
#!/bin/sh
# Build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tbGameTop -f sim.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/VtbGameTop 2>&1); then
	echo "$output"
	echo "Simulation exited with an error"
	exit 1
fi
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
